//--- mmio_system.f
+incdir+source
source/mmio_pkg.sv
source/mmio_uart_tx.sv
source/mmio_uart_rx.sv
source/mmio_clint.sv
source/data_ram.sv
source/mmio_ctrl.sv
source/mmio_system.sv
tests/mmio_system_checker.sv
tests/mmio_system_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mmio_system_tb
FILELIST  ?= mmio_system.f
LOG       ?= sim.log
SEED      ?= 39113
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		-Grand_seed=$(SEED) --Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/mmio_system_tb.sv
`default_nettype none
`include "mmio_defines.svh"

module mmio_system_tb #(
    parameter int rand_seed = 32'h98c9
);
    localparam int wait_limit = 200;

    logic                  clk;
    logic                  reset;
    mmio_pkg::mmio_req_t   dreq;
    logic                  dreq_ready;
    mmio_pkg::mmio_resp_t  dresp;
    wire                   uart_line; // tx looped back to rx.
    logic                  uart_rx_pending;
    logic                  mti_pending;
    logic [31:0]           shadow [`MMIO_RAM_WORDS];
    integer                seed;
    int                    latency;

    mmio_system u_dut (
        .clk(clk), .reset(reset), .dreq(dreq), .dreq_ready(dreq_ready), .dresp(dresp),
        .uart_rx(uart_line), .uart_tx(uart_line), .uart_rx_pending(uart_rx_pending),
        .mti_pending(mti_pending)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        assert (got === want) else begin
            report_failure($sformatf("ERROR t=%0t %s: got %h expected %h",
                                     $time, name, got, want));
        end
    endtask

    // one request, from drive to response; latency counts falling edges.
    task automatic bus_access(input logic [31:0] req_addr, input logic req_wen,
                              input logic [31:0] req_wdata, input logic [3:0] req_mask,
                              output mmio_pkg::mmio_resp_t resp);
        int waited;
        dreq = '{valid: 1'b1, addr: req_addr, wen: req_wen, wdata: req_wdata,
                 wmask: req_mask};
        latency = 0;
        waited = 0;
        while (!dreq_ready) begin
            @(negedge clk);
            waited++;
            latency++;
            if (waited > wait_limit) report_failure("timeout waiting for dreq_ready");
        end
        @(negedge clk);
        latency++;
        dreq = '0;
        waited = 0;
        while (!dresp.valid) begin
            @(negedge clk);
            waited++;
            latency++;
            if (waited > wait_limit) report_failure("timeout waiting for a response");
        end
        resp = dresp;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] mask);
        mmio_pkg::mmio_resp_t resp;
        bus_access(addr, 1'b1, data, mask, resp);
        expect_equal("dresp.error", 32'(resp.error), 32'd0);
    endtask

    task automatic read_expect(input logic [31:0] addr, input logic [31:0] want);
        mmio_pkg::mmio_resp_t resp;
        bus_access(addr, 1'b0, 32'd0, 4'h0, resp);
        expect_equal("dresp.error", 32'(resp.error), 32'd0);
        expect_equal("dresp.rdata", resp.rdata, want);
    endtask

    task automatic wait_rx_pending();
        int waited;
        waited = 0;
        while (!uart_rx_pending) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) report_failure("timeout waiting for a received byte");
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0] mask);
        logic [31:0] result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) result[8*b +: 8] = data[8*b +: 8];
        end
        return result;
    endfunction

    // reads words 0..count-1 with valid held high, one request per cycle.
    task automatic read_burst(input int count);
        logic [31:0] want_q[$];
        int          sent;
        int          got;
        int          waited;
        logic        accepted;
        sent = 0;
        got = 0;
        waited = 0;
        dreq = '{valid: 1'b1, addr: `MMIO_RAM_BASE, wen: 1'b0, wdata: '0, wmask: '0};
        while (got < count) begin
            accepted = dreq.valid && dreq_ready;
            @(negedge clk);
            waited++;
            if (waited > wait_limit) report_failure("timeout in the read burst");
            if (accepted) begin
                want_q.push_back(shadow[sent]);
                sent++;
                if (sent < count) dreq.addr = `MMIO_RAM_BASE + 32'(4 * sent);
                else dreq = '0;
            end
            if (dresp.valid) begin
                assert (want_q.size() > 0) else report_failure("response with no read pending");
                expect_equal("dresp.rdata", dresp.rdata, want_q.pop_front());
                got++;
            end
        end
        assert (waited == count) else begin
            report_failure($sformatf("burst of %0d reads took %0d cycles", count, waited));
        end
    endtask

    initial begin
        mmio_pkg::mmio_resp_t resp;
        logic [31:0]          data;
        logic [3:0]           mask;
        logic [7:0]           first_byte;
        logic [7:0]           second_byte;
        int                   idx;
        int                   waited;
        seed = rand_seed;
        reset = 1'b1;
        dreq = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // fill words 0..31, then merge random masked writes.
        for (int i = 0; i < 32; i++) begin
            data = $random(seed);
            write_word(`MMIO_RAM_BASE + 32'(4 * i), data, 4'hf);
            shadow[i] = data;
        end
        for (int i = 0; i < 40; i++) begin
            idx = $random(seed) & 31;
            data = $random(seed);
            mask = 4'($random(seed));
            write_word(`MMIO_RAM_BASE + 32'(4 * idx), data, mask);
            shadow[idx] = merge_bytes(shadow[idx], data, mask);
            idx = $random(seed) & 31;
            read_expect(`MMIO_RAM_BASE + 32'(4 * idx), shadow[idx]);
        end
        bus_access(`MMIO_RAM_BASE + 32'(4 * `MMIO_RAM_WORDS), 1'b0, 32'd0, 4'h0, resp);
        expect_equal("dresp.error", 32'(resp.error), 32'd1);

        first_byte = 8'($random(seed));
        write_word(`MMIO_UART_TX_ADDR, {24'd0, first_byte}, 4'h1);
        wait_rx_pending();
        read_expect(`MMIO_UART_RX_ADDR, {23'd0, 1'b1, first_byte});
        expect_equal("uart_rx_pending", 32'(uart_rx_pending), 32'd0);
        read_expect(`MMIO_UART_RX_ADDR, {23'd0, 1'b0, first_byte});

        // second write waits out the first frame.
        first_byte = 8'($random(seed));
        second_byte = 8'($random(seed));
        write_word(`MMIO_UART_TX_ADDR, {24'd0, first_byte}, 4'h1);
        write_word(`MMIO_UART_TX_ADDR, {24'd0, second_byte}, 4'h1);
        assert (latency >= 10 * `MMIO_CLKS_PER_BIT) else begin
            report_failure("second TX write completed while the first frame was on the line");
        end
        read_expect(`MMIO_UART_TX_ADDR, 32'd1);
        wait_rx_pending();
        read_expect(`MMIO_UART_RX_ADDR, {23'd0, 1'b1, first_byte});
        wait_rx_pending();
        read_expect(`MMIO_UART_RX_ADDR, {23'd0, 1'b1, second_byte});

        write_word(`MMIO_CLINT_BASE, 32'd1000, 4'hf);
        write_word(`MMIO_CLINT_BASE + 32'd8, 32'd1012, 4'hf);
        expect_equal("mti_pending", 32'(mti_pending), 32'd0);
        waited = 0;
        while (!mti_pending) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) report_failure("timeout waiting for mti_pending");
        end
        write_word(`MMIO_CLINT_BASE + 32'd8, 32'hffff_ffff, 4'hf);
        expect_equal("mti_pending", 32'(mti_pending), 32'd0);
        read_expect(`MMIO_CLINT_BASE + 32'd8, 32'hffff_ffff);

        read_burst(16);

        if (u_dut.u_checker.failed) begin
            report_failure("a bound assertion failed");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (u_dut.u_checker.failed) report_failure("a bound assertion failed");
    end

endmodule

`default_nettype wire

//--- tests/mmio_system_checker.sv
`default_nettype none
`include "mmio_defines.svh"

module mmio_system_checker (
    input wire                        clk,
    input wire                        reset,
    input wire mmio_pkg::mmio_req_t   dreq,
    input wire                        dreq_ready,
    input wire mmio_pkg::mmio_resp_t  dresp,
    input wire                        tx_busy,
    input wire                        uart_tx,
    input wire                        mti_pending
);
    logic                  failed = 1'b0;
    logic                  accept;
    logic                  wr_accept;
    logic [1:0]            in_flight; // accepted requests still owed a response.
    logic [6:0]            age;
    logic                  stalled;   // tx write parked behind a busy frame.
    logic [`MMIO_XLEN-1:0] model_time;
    logic [`MMIO_XLEN-1:0] model_cmp;

    assign accept    = dreq.valid && dreq_ready;
    assign wr_accept = accept && dreq.wen;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= '0;
            age       <= '0;
        end else begin
            in_flight <= in_flight + 2'(accept) - 2'(dresp.valid);
            if (in_flight != 2'd0 && !dresp.valid) age <= age + 7'd1;
            else age <= '0;
        end
    end

    // timer and stall seen from the cpu port.
    always_ff @(posedge clk) begin
        if (reset) begin
            stalled    <= 1'b0;
            model_time <= '0;
            model_cmp  <= '1;
        end else begin
            if (wr_accept && dreq.addr == `MMIO_UART_TX_ADDR && tx_busy) stalled <= 1'b1;
            else if (!tx_busy) stalled <= 1'b0;
            if (wr_accept && dreq.addr == `MMIO_CLINT_BASE) model_time <= dreq.wdata;
            else model_time <= model_time + 1'b1;
            if (wr_accept && dreq.addr == `MMIO_CLINT_BASE + 32'd8) begin
                model_cmp <= dreq.wdata;
            end
        end
    end

    resp_has_request: assert property (@(posedge clk) disable iff (reset)
        dresp.valid |-> in_flight == 2'd1)
    else begin
        failed = 1'b1;
        $error("response without an accepted request");
    end

    request_answered: assert property (@(posedge clk) disable iff (reset)
        in_flight <= 2'd1 && age < 7'd100)
    else begin
        failed = 1'b1;
        $error("accepted request left without a response");
    end

    stall_blocks_cpu: assert property (@(posedge clk) disable iff (reset)
        stalled |-> !dreq_ready)
    else begin
        failed = 1'b1;
        $error("dreq_ready high while waiting on a target");
    end

    tx_idle_high: assert property (@(posedge clk) disable iff (reset)
        !tx_busy |-> uart_tx)
    else begin
        failed = 1'b1;
        $error("uart_tx low while the transmitter is idle");
    end

    timer_compare: assert property (@(posedge clk) disable iff (reset)
        mti_pending == (model_time >= model_cmp))
    else begin
        failed = 1'b1;
        $error("mti_pending does not follow mtime >= mtimecmp");
    end

endmodule

bind mmio_system mmio_system_checker u_checker (
    .clk(clk), .reset(reset), .dreq(dreq), .dreq_ready(dreq_ready), .dresp(dresp),
    .tx_busy(u_ctrl.u_uart_tx.busy), .uart_tx(uart_tx), .mti_pending(mti_pending)
);

`default_nettype wire

//--- source/mmio_system.sv
`default_nettype none

module mmio_system (
    input  wire                      clk,
    input  wire                      reset,
    input  wire mmio_pkg::mmio_req_t dreq,
    output logic                     dreq_ready,
    output mmio_pkg::mmio_resp_t     dresp,
    input  wire                      uart_rx,
    output logic                     uart_tx,
    output logic                     uart_rx_pending,
    output logic                     mti_pending
);
    mmio_pkg::mmio_req_t  ram_req;
    mmio_pkg::mmio_resp_t ram_resp;
    logic                 ram_ready;

    mmio_ctrl u_ctrl (
        .clk(clk),
        .reset(reset),
        .dreq(dreq),
        .dreq_ready(dreq_ready),
        .dresp(dresp),
        .ram_req(ram_req),
        .ram_ready(ram_ready),
        .ram_resp(ram_resp),
        .uart_rx(uart_rx),
        .uart_tx(uart_tx),
        .uart_rx_pending(uart_rx_pending),
        .mti_pending(mti_pending)
    );

    // the request valid bit doubles as the ram select.
    data_ram u_ram (
        .clk(clk),
        .reset(reset),
        .req(ram_req),
        .sel(ram_req.valid),
        .ready(ram_ready),
        .resp(ram_resp)
    );

endmodule

`default_nettype wire

//--- source/mmio_ctrl.sv
`default_nettype none
`include "mmio_defines.svh"

module mmio_ctrl (
    input  wire                      clk,
    input  wire                      reset,
    input  wire mmio_pkg::mmio_req_t dreq,
    output logic                     dreq_ready,
    output mmio_pkg::mmio_resp_t     dresp,
    output mmio_pkg::mmio_req_t      ram_req,
    input  wire                      ram_ready,
    input  wire mmio_pkg::mmio_resp_t ram_resp,
    input  wire                      uart_rx,
    output logic                     uart_tx,
    output logic                     uart_rx_pending,
    output logic                     mti_pending
);
    localparam logic [`MMIO_XLEN-1:0] WIN_MASK = {{(`MMIO_XLEN-4){1'b1}}, 4'h0};

    mmio_pkg::ctrl_state_e state;
    mmio_pkg::mmio_req_t   s_req;
    mmio_pkg::target_e     s_tgt;
    mmio_pkg::target_e     new_tgt;
    mmio_pkg::target_e     cur_tgt;
    mmio_pkg::mmio_req_t   cur_req;
    mmio_pkg::mmio_req_t   tgt_req;
    mmio_pkg::mmio_resp_t  sel_resp;
    mmio_pkg::mmio_resp_t  tx_resp;
    mmio_pkg::mmio_resp_t  rx_resp;
    mmio_pkg::mmio_resp_t  clint_resp;
    logic                  s_valid;
    logic                  issue;
    logic                  cur_ready;
    logic                  ram_sel;
    logic                  tx_sel;
    logic                  rx_sel;
    logic                  clint_sel;
    logic                  tx_ready;
    logic                  rx_ready;
    logic                  clint_ready;

    function automatic mmio_pkg::target_e decode(input logic [`MMIO_XLEN-1:0] addr);
        if ((addr & WIN_MASK) == `MMIO_UART_TX_ADDR) return mmio_pkg::TGT_UART_TX;
        if ((addr & WIN_MASK) == `MMIO_UART_RX_ADDR) return mmio_pkg::TGT_UART_RX;
        if ((addr & WIN_MASK) == `MMIO_CLINT_BASE) return mmio_pkg::TGT_CLINT;
        return mmio_pkg::TGT_MEM; // everything else falls to memory.
    endfunction

    function automatic logic [`MMIO_XLEN-1:0] base_of(input mmio_pkg::target_e tgt);
        case (tgt)
            mmio_pkg::TGT_UART_TX: return `MMIO_UART_TX_ADDR;
            mmio_pkg::TGT_UART_RX: return `MMIO_UART_RX_ADDR;
            mmio_pkg::TGT_CLINT:   return `MMIO_CLINT_BASE;
            default:               return `MMIO_RAM_BASE;
        endcase
    endfunction

    // response stage.
    always_comb begin
        case (s_tgt)
            mmio_pkg::TGT_UART_TX: sel_resp = tx_resp;
            mmio_pkg::TGT_UART_RX: sel_resp = rx_resp;
            mmio_pkg::TGT_CLINT:   sel_resp = clint_resp;
            default:               sel_resp = ram_resp;
        endcase
        s_valid = (state == mmio_pkg::WAIT_VALID) && sel_resp.valid;
        dreq_ready = (state == mmio_pkg::IDLE) || s_valid; // next request rides on the response.
        dresp = sel_resp;
        dresp.valid = s_valid;
    end

    // issue stage.
    always_comb begin
        new_tgt = decode(dreq.addr);
        if (state == mmio_pkg::WAIT_READY) begin
            cur_req = s_req;
            cur_tgt = s_tgt;
        end else begin
            cur_req = dreq;
            cur_tgt = new_tgt;
        end
        issue = (state == mmio_pkg::WAIT_READY) || (dreq_ready && dreq.valid);
        tgt_req = cur_req;
        tgt_req.valid = issue;
        tgt_req.addr = cur_req.addr - base_of(cur_tgt); // offset within the window.
        ram_sel   = issue && (cur_tgt == mmio_pkg::TGT_MEM);
        tx_sel    = issue && (cur_tgt == mmio_pkg::TGT_UART_TX);
        rx_sel    = issue && (cur_tgt == mmio_pkg::TGT_UART_RX);
        clint_sel = issue && (cur_tgt == mmio_pkg::TGT_CLINT);
        ram_req = tgt_req;
        ram_req.valid = ram_sel;
    end

    always_comb begin
        case (cur_tgt)
            mmio_pkg::TGT_UART_TX: cur_ready = tx_ready;
            mmio_pkg::TGT_UART_RX: cur_ready = rx_ready;
            mmio_pkg::TGT_CLINT:   cur_ready = clint_ready;
            default:               cur_ready = ram_ready;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mmio_pkg::IDLE;
        end else begin
            case (state)
                mmio_pkg::WAIT_READY: if (cur_ready) state <= mmio_pkg::WAIT_VALID;
                default: if (dreq_ready) begin
                    if (!dreq.valid) state <= mmio_pkg::IDLE;
                    else if (cur_ready) state <= mmio_pkg::WAIT_VALID;
                    else state <= mmio_pkg::WAIT_READY;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dreq_ready && dreq.valid) begin
            s_req <= dreq;
            s_tgt <= new_tgt;
        end
    end

    mmio_uart_tx u_uart_tx (
        .clk(clk), .reset(reset), .req(tgt_req), .sel(tx_sel),
        .ready(tx_ready), .resp(tx_resp), .uart_tx(uart_tx)
    );

    mmio_uart_rx u_uart_rx (
        .clk(clk), .reset(reset), .req(tgt_req), .sel(rx_sel),
        .ready(rx_ready), .resp(rx_resp), .uart_rx(uart_rx),
        .uart_rx_pending(uart_rx_pending)
    );

    mmio_clint u_clint (
        .clk(clk), .reset(reset), .req(tgt_req), .sel(clint_sel),
        .ready(clint_ready), .resp(clint_resp), .mti_pending(mti_pending)
    );

endmodule

`default_nettype wire

//--- source/data_ram.sv
`default_nettype none
`include "mmio_defines.svh"

module data_ram (
    input  wire                      clk,
    input  wire                      reset,
    input  wire mmio_pkg::mmio_req_t req,
    input  wire                      sel,
    output logic                     ready,
    output mmio_pkg::mmio_resp_t     resp
);
    localparam int IDX_W = $clog2(`MMIO_RAM_WORDS);

    logic [`MMIO_XLEN-1:0] mem [`MMIO_RAM_WORDS];
    logic [IDX_W-1:0]      idx;
    logic                  in_range;
    logic                  resp_valid;
    logic                  err_q;
    logic [`MMIO_XLEN-1:0] rdata_q;

    assign ready    = 1'b1;
    assign idx      = req.addr[IDX_W+1:2];
    assign in_range = {2'b00, req.addr[`MMIO_XLEN-1:2]} < `MMIO_XLEN'(`MMIO_RAM_WORDS);
    assign resp     = '{valid: resp_valid, rdata: rdata_q, error: err_q};

    always_ff @(posedge clk) begin
        if (sel && req.wen && in_range) begin
            for (int b = 0; b < `MMIO_XLEN / 8; b++) begin
                if (req.wmask[b]) mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
        rdata_q <= mem[idx]; // old data on a write.
        err_q   <= !in_range;
    end

    always_ff @(posedge clk) begin
        if (reset) resp_valid <= 1'b0;
        else resp_valid <= sel;
    end

endmodule

`default_nettype wire

//--- source/mmio_clint.sv
`default_nettype none
`include "mmio_defines.svh"

module mmio_clint (
    input  wire                      clk,
    input  wire                      reset,
    input  wire mmio_pkg::mmio_req_t req,
    input  wire                      sel,
    output logic                     ready,
    output mmio_pkg::mmio_resp_t     resp,
    output logic                     mti_pending
);
    logic [`MMIO_XLEN-1:0] mtime;
    logic [`MMIO_XLEN-1:0] mtimecmp;
    logic [`MMIO_XLEN-1:0] rdata_q;
    logic                  resp_valid;
    logic                  is_cmp;
    logic                  wr_time;
    logic                  wr_cmp;

    assign ready       = 1'b1;
    assign is_cmp      = (req.addr[3:0] == 4'h8);
    assign wr_time     = sel && req.wen && (req.addr[3:0] == 4'h0);
    assign wr_cmp      = sel && req.wen && is_cmp;
    assign mti_pending = (mtime >= mtimecmp);
    assign resp        = '{valid: resp_valid, rdata: rdata_q, error: 1'b0};

    always_ff @(posedge clk) begin
        if (reset) begin
            mtime      <= '0;
            mtimecmp   <= '1;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= sel;
            if (wr_time) mtime <= req.wdata; // a write replaces this cycle's increment.
            else mtime <= mtime + 1'b1;
            if (wr_cmp) mtimecmp <= req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        rdata_q <= is_cmp ? mtimecmp : mtime;
    end

endmodule

`default_nettype wire

//--- source/mmio_uart_rx.sv
`default_nettype none
`include "mmio_defines.svh"

module mmio_uart_rx (
    input  wire                      clk,
    input  wire                      reset,
    input  wire mmio_pkg::mmio_req_t req,
    input  wire                      sel,
    output logic                     ready,
    output mmio_pkg::mmio_resp_t     resp,
    input  wire                      uart_rx,
    output logic                     uart_rx_pending
);
    localparam int TICK_W = $clog2(`MMIO_CLKS_PER_BIT);

    logic [1:0]            sync;
    logic                  rx_s;
    logic                  active;
    logic [TICK_W-1:0]     tick;
    logic [3:0]            bit_cnt;
    logic                  sample;
    logic                  byte_done;
    logic [7:0]            shift;
    logic [7:0]            hold;
    logic                  pending;
    logic                  resp_valid;
    logic [`MMIO_XLEN-1:0] rdata_q;

    assign ready           = 1'b1;
    assign rx_s            = sync[1];
    assign sample          = active && (tick == '0);
    assign byte_done       = sample && (bit_cnt == 4'd9) && rx_s; // stop bit must be high.
    assign uart_rx_pending = pending;
    assign resp            = '{valid: resp_valid, rdata: rdata_q, error: 1'b0};

    always_ff @(posedge clk) begin
        if (reset) sync <= 2'b11;
        else sync <= {sync[0], uart_rx};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active  <= 1'b0;
            tick    <= '0;
            bit_cnt <= '0;
        end else if (!active) begin
            if (!rx_s) begin
                active  <= 1'b1;
                tick    <= TICK_W'(`MMIO_CLKS_PER_BIT / 2 - 1); // land mid start bit.
                bit_cnt <= '0;
            end
        end else if (tick != '0) begin
            tick <= tick - 1'b1;
        end else begin
            tick    <= TICK_W'(`MMIO_CLKS_PER_BIT - 1);
            bit_cnt <= bit_cnt + 4'd1;
            if ((bit_cnt == 4'd0 && rx_s) || bit_cnt == 4'd9) active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (sample && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) shift <= {rx_s, shift[7:1]};
        if (byte_done) hold <= shift;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending    <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= sel;
            if (byte_done) pending <= 1'b1; // new byte wins over a read.
            else if (sel && !req.wen) pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        rdata_q <= {{(`MMIO_XLEN-9){1'b0}}, pending, hold};
    end

endmodule

`default_nettype wire

//--- source/mmio_uart_tx.sv
`default_nettype none
`include "mmio_defines.svh"

module mmio_uart_tx (
    input  wire                      clk,
    input  wire                      reset,
    input  wire mmio_pkg::mmio_req_t req,
    input  wire                      sel,
    output logic                     ready,
    output mmio_pkg::mmio_resp_t     resp,
    output logic                     uart_tx
);
    localparam int TICK_W = $clog2(`MMIO_CLKS_PER_BIT);

    logic                  busy;
    logic [9:0]            shift;   // stop, data, start.
    logic [TICK_W-1:0]     tick;
    logic [3:0]            bit_cnt;
    logic                  accept;
    logic                  resp_valid;
    logic [`MMIO_XLEN-1:0] rdata_q;

    assign ready   = !(busy && req.wen); // reads never stall.
    assign accept  = sel && ready;
    assign uart_tx = shift[0];
    assign resp    = '{valid: resp_valid, rdata: rdata_q, error: 1'b0};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            shift   <= '1;
            tick    <= '0;
            bit_cnt <= '0;
        end else if (accept && req.wen) begin
            busy    <= 1'b1;
            shift   <= {1'b1, req.wdata[7:0], 1'b0};
            tick    <= '0;
            bit_cnt <= '0;
        end else if (busy) begin
            if (tick == TICK_W'(`MMIO_CLKS_PER_BIT - 1)) begin
                tick  <= '0;
                shift <= {1'b1, shift[9:1]}; // line rests high after the stop bit.
                if (bit_cnt == 4'd9) busy <= 1'b0;
                else bit_cnt <= bit_cnt + 4'd1;
            end else begin
                tick <= tick + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) resp_valid <= 1'b0;
        else resp_valid <= accept;
    end

    always_ff @(posedge clk) begin
        rdata_q <= {{(`MMIO_XLEN-1){1'b0}}, busy};
    end

endmodule

`default_nettype wire

//--- source/mmio_pkg.sv
`default_nettype none
`include "mmio_defines.svh"

package mmio_pkg;

    typedef struct packed {
        logic                      valid;
        logic [`MMIO_XLEN-1:0]     addr;
        logic                      wen;
        logic [`MMIO_XLEN-1:0]     wdata;
        logic [`MMIO_XLEN/8-1:0]   wmask; // one bit per byte lane.
    } mmio_req_t;

    typedef struct packed {
        logic                  valid;
        logic [`MMIO_XLEN-1:0] rdata;
        logic                  error;
    } mmio_resp_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_READY,
        WAIT_VALID
    } ctrl_state_e;

    // decoded destination of a request.
    typedef enum logic [1:0] {
        TGT_MEM,
        TGT_UART_TX,
        TGT_UART_RX,
        TGT_CLINT
    } target_e;

endpackage

`default_nettype wire

//--- source/mmio_defines.svh
`ifndef MMIO_DEFINES_SVH
`define MMIO_DEFINES_SVH

// data path and address width.
`define MMIO_XLEN 32

`define MMIO_RAM_WORDS 256

// uart bit time, short for simulation.
`define MMIO_CLKS_PER_BIT 4

// address map.
`define MMIO_UART_TX_ADDR 32'h1000_0000
`define MMIO_UART_RX_ADDR 32'h1000_0010
`define MMIO_CLINT_BASE 32'h0200_0000
`define MMIO_RAM_BASE 32'h8000_0000

`endif
